/* Makefile */
VERILATOR ?= verilator
TOP       ?= dmb_ctrl_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJ_DIR)

/* sim.f */
src/dmb_timing_pkg.sv
src/dmb_vme_pkg.sv
src/vme_dev_if.sv
src/clk_enable_gen.sv
src/vme_timers.sv
src/reset_jtag_init.sv
src/cfeb_select.sv
src/vprom_enable.sv
src/dmb_ctrl_top.sv
verif/dmb_ctrl_tb.sv

/* src/cfeb_select.sv */
`timescale 1ns/100ps

module cfeb_select (
	input  logic                                fastclk,
	input  logic                                jtimer_clr,
	input  logic                                sys_rst_i,
	vme_dev_if.dev                              bus,
	input  logic                                cfeb_tck_i,
	input  dmb_vme_pkg::cfeb_sel_t              cfeb_tdo_i,
	output logic                                dtack_b_o,
	output logic [dmb_vme_pkg::VME_DATA_W-1:0]  outdata_o,
	output dmb_vme_pkg::cfeb_sel_t              cfeb_tck_o,
	output logic                                cfeb_tdo_o
);

	logic                   sel_write;
	logic                   sel_read;
	logic                   dt_wr_q;
	logic                   dt_rd_q;
	dmb_vme_pkg::cfeb_sel_t sel_q;

	// Command decode for device 1
	assign sel_write = bus.device[dmb_vme_pkg::DEV_CFEB]
		&& (bus.command == dmb_vme_pkg::CMD_CFEB_SEL);
	assign sel_read  = bus.device[dmb_vme_pkg::DEV_CFEB]
		&& (bus.command == dmb_vme_pkg::CMD_CFEB_READ);

	// Acknowledge one cycle behind the strobe
	always_ff @(posedge fastclk or posedge jtimer_clr) begin
		if (jtimer_clr) begin
			dt_wr_q <= 1'b0;
			dt_rd_q <= 1'b0;
		end else begin
			dt_wr_q <= bus.strobe & sel_write;
			dt_rd_q <= bus.strobe & sel_read;
		end
	end

	assign dtack_b_o = ~(dt_wr_q | dt_rd_q);

	// Select register
	always_ff @(posedge fastclk or posedge jtimer_clr) begin
		if (jtimer_clr) begin
			sel_q <= dmb_vme_pkg::CFEB_SEL_RESET;
		end else if (sys_rst_i) begin
			sel_q <= dmb_vme_pkg::CFEB_SEL_RESET;
		end else if (sel_write && bus.strbce) begin
			sel_q <= bus.indata[dmb_vme_pkg::NUM_CFEB-1:0];
		end
	end

	always_comb begin
		outdata_o = '0;
		if (bus.write_b && sel_read) begin
			outdata_o[dmb_vme_pkg::NUM_CFEB-1:0] = sel_q;
		end
	end

	//////////////////////////////////////////////////
	// JTAG routing to the boards
	//////////////////////////////////////////////////
	assign cfeb_tck_o = {dmb_vme_pkg::NUM_CFEB{cfeb_tck_i}} & sel_q;

	// TDO only comes back from a single selected board
	always_comb begin
		cfeb_tdo_o = 1'b0;
		if ($onehot(sel_q)) begin
			cfeb_tdo_o = |(cfeb_tdo_i & sel_q);
		end
	end

	a_dtack_after_strobe: assert property (
		@(posedge fastclk) disable iff (jtimer_clr)
		!dtack_b_o |-> $past(bus.strobe)
	);

endmodule

/* src/clk_enable_gen.sv */
`timescale 1ns/100ps

module clk_enable_gen (
	input  logic fastclk,
	input  logic jtimer_clr,
	output logic mid_en_o,
	output logic slow_en_o,
	output logic slow2_en_o
);

	logic [dmb_timing_pkg::PHASE_W-1:0] phase_q;

	// Free-running phase, wraps once per slow2 period
	always_ff @(posedge fastclk or posedge jtimer_clr) begin
		if (jtimer_clr) begin
			phase_q <= '0;
		end else begin
			phase_q <= phase_q + 1'b1;
		end
	end

	// All three enables decode phase zero of their own period
	always_ff @(posedge fastclk or posedge jtimer_clr) begin
		if (jtimer_clr) begin
			mid_en_o   <= 1'b0;
			slow_en_o  <= 1'b0;
			slow2_en_o <= 1'b0;
		end else begin
			mid_en_o   <= (phase_q & dmb_timing_pkg::MID_MASK) == '0;
			slow_en_o  <= (phase_q & dmb_timing_pkg::SLOW_MASK) == '0;
			slow2_en_o <= (phase_q & dmb_timing_pkg::SLOW2_MASK) == '0;
		end
	end

	//////////////////////////////////////////////////
	// Enables stay nested
	//////////////////////////////////////////////////
	a_en_nested: assert property (
		@(posedge fastclk) disable iff (jtimer_clr)
		(slow2_en_o |-> slow_en_o) and (slow_en_o |-> mid_en_o)
	);

endmodule

/* src/dmb_ctrl_top.sv */
`timescale 1ns/100ps

module dmb_ctrl_top (
	input  logic                                 fastclk,
	input  logic                                 jtimer_clr,
	input  logic                                 strobe_i,
	input  logic                                 strbce_i,
	input  logic                                 write_b_i,
	input  logic [dmb_vme_pkg::NUM_DEVICES-1:0]  device_i,
	input  logic [dmb_vme_pkg::CMD_W-1:0]        command_i,
	input  logic [dmb_vme_pkg::VME_DATA_W-1:0]   indata_i,
	input  logic                                 softrst_i,
	input  logic                                 donetrg_i,
	input  logic                                 vmeready_i,
	input  logic                                 tovme_b_i,
	input  logic                                 cfeb_tck_i,
	input  dmb_vme_pkg::cfeb_sel_t               cfeb_tdo_i,
	output logic                                 dtack_b_o,
	output logic [dmb_vme_pkg::VME_DATA_W-1:0]   outdata_o,
	output logic                                 data_oe_b_o,
	output logic                                 vme_ready_b_o,
	output logic                                 jtag_init_o,
	output dmb_vme_pkg::cfeb_sel_t               cfeb_tck_o,
	output logic                                 cfeb_tdo_o,
	output logic                                 vprom_en_o
);

	logic mid_en;
	logic slow_en;
	logic slow2_en;
	logic fpga_rst;
	logic sys_rst;

	vme_dev_if bus ();

	// Decoded access from the command decoder
	assign bus.strobe  = strobe_i;
	assign bus.strbce  = strbce_i;
	assign bus.write_b = write_b_i;
	assign bus.device  = device_i;
	assign bus.command = command_i;
	assign bus.indata  = indata_i;

	clk_enable_gen u_clk_en (
		.fastclk    (fastclk),
		.jtimer_clr (jtimer_clr),
		.mid_en_o   (mid_en),
		.slow_en_o  (slow_en),
		.slow2_en_o (slow2_en)
	);

	vme_timers u_vme_timers (
		.fastclk       (fastclk),
		.jtimer_clr    (jtimer_clr),
		.mid_en_i      (mid_en),
		.slow_en_i     (slow_en),
		.tovme_b_i     (tovme_b_i),
		.vmeready_i    (vmeready_i),
		.data_oe_b_o   (data_oe_b_o),
		.vme_ready_b_o (vme_ready_b_o),
		.fpga_rst_o    (fpga_rst)
	);

	reset_jtag_init u_rst_jinit (
		.fastclk     (fastclk),
		.jtimer_clr  (jtimer_clr),
		.slow2_en_i  (slow2_en),
		.softrst_i   (softrst_i),
		.donetrg_i   (donetrg_i),
		.fpga_rst_i  (fpga_rst),
		.sys_rst_o   (sys_rst),
		.jtag_init_o (jtag_init_o)
	);

	//////////////////////////////////////////////////
	// Devices
	//////////////////////////////////////////////////
	// Device 1 is the only one that acknowledges
	cfeb_select u_cfeb_sel (
		.fastclk    (fastclk),
		.jtimer_clr (jtimer_clr),
		.sys_rst_i  (sys_rst),
		.bus        (bus),
		.cfeb_tck_i (cfeb_tck_i),
		.cfeb_tdo_i (cfeb_tdo_i),
		.dtack_b_o  (dtack_b_o),
		.outdata_o  (outdata_o),
		.cfeb_tck_o (cfeb_tck_o),
		.cfeb_tdo_o (cfeb_tdo_o)
	);

	vprom_enable u_vprom_en (
		.fastclk     (fastclk),
		.jtimer_clr  (jtimer_clr),
		.sys_rst_i   (sys_rst),
		.slow2_en_i  (slow2_en),
		.jtag_init_i (jtag_init_o),
		.bus         (bus),
		.vprom_en_o  (vprom_en_o)
	);

endmodule

/* src/dmb_timing_pkg.sv */
package dmb_timing_pkg;

	// Phase counter for the clock enables
	localparam int PHASE_W = 5;

	// Enable periods in fastclk cycles
	localparam int MID_DIV   = 4;
	localparam int SLOW_DIV  = 16;
	localparam int SLOW2_DIV = 32;

	// Phase bits that must be zero for each enable
	localparam logic [PHASE_W-1:0] MID_MASK   = PHASE_W'(MID_DIV - 1);
	localparam logic [PHASE_W-1:0] SLOW_MASK  = PHASE_W'(SLOW_DIV - 1);
	localparam logic [PHASE_W-1:0] SLOW2_MASK = PHASE_W'(SLOW2_DIV - 1);

	// VME data output enable window, top bit closes it
	localparam int DOE_TIMER_W = 8;

	// VME ready delay, full scale means ready
	localparam int VRD_TIMER_W = 16;

	// JTAG init sequencer
	localparam int JINIT_TIMER_W    = 6;
	localparam int JINIT_ACTIVE_BIT = 4;
	localparam int JINIT_DONE_BIT   = 5;

	// Device 4 enable hold
	localparam int DVC_HOLD_W = 8;

endpackage

/* src/dmb_vme_pkg.sv */
package dmb_vme_pkg;

	localparam int VME_DATA_W  = 16;
	localparam int CMD_W       = 10;
	localparam int NUM_DEVICES = 10;

	// Device lines from the command decoder
	localparam int DEV_CFEB  = 1;
	localparam int DEV_VPROM = 4;

	// Device 1 commands
	localparam logic [CMD_W-1:0] CMD_CFEB_SEL  = CMD_W'(8);
	localparam logic [CMD_W-1:0] CMD_CFEB_READ = CMD_W'(9);

	// Front-end boards on the CFEB JTAG chain
	localparam int NUM_CFEB = 5;

	// One bit per board, board 1 in bit 0
	typedef logic [NUM_CFEB-1:0] cfeb_sel_t;

	// All boards selected out of reset
	localparam cfeb_sel_t CFEB_SEL_RESET = '1;

endpackage

/* src/reset_jtag_init.sv */
`timescale 1ns/100ps

module reset_jtag_init (
	input  logic fastclk,
	input  logic jtimer_clr,
	input  logic slow2_en_i,
	input  logic softrst_i,
	input  logic donetrg_i,
	input  logic fpga_rst_i,
	output logic sys_rst_o,
	output logic jtag_init_o
);

	logic                                     rst_comb;
	logic                                     sys_rst_d;
	logic                                     rst_fall;
	logic                                     start_q;
	logic [dmb_timing_pkg::JINIT_TIMER_W-1:0] jinit_q;
	logic                                     jinit_done;

	// Soft reset only counts once the FPGAs are configured
	assign rst_comb = jtimer_clr | (softrst_i & donetrg_i) | fpga_rst_i;

	always_ff @(posedge fastclk or posedge jtimer_clr) begin
		if (jtimer_clr) begin
			sys_rst_o <= 1'b1;
			sys_rst_d <= 1'b1;
		end else begin
			sys_rst_o <= rst_comb;
			sys_rst_d <= sys_rst_o;
		end
	end

	assign rst_fall   = sys_rst_d & ~sys_rst_o;
	assign jinit_done = jinit_q[dmb_timing_pkg::JINIT_DONE_BIT];

	//////////////////////////////////////////////////
	// JTAG init sequencer
	//////////////////////////////////////////////////
	always_ff @(posedge fastclk or posedge jtimer_clr) begin
		if (jtimer_clr) begin
			start_q <= 1'b0;
			jinit_q <= '0;
		end else if (sys_rst_o || jinit_done) begin
			start_q <= 1'b0;
			jinit_q <= '0;
		end else begin
			start_q <= start_q | rst_fall;
			if (slow2_en_i && start_q) begin
				jinit_q <= jinit_q + 1'b1;
			end
		end
	end

	// High from count 16 up to count 32
	assign jtag_init_o = jinit_q[dmb_timing_pkg::JINIT_ACTIVE_BIT];

	a_init_needs_start: assert property (
		@(posedge fastclk) disable iff (jtimer_clr)
		jtag_init_o |-> start_q
	);

endmodule

/* src/vme_dev_if.sv */
`timescale 1ns/100ps

interface vme_dev_if;

	// Decoded VME access, valid while strobe is high
	logic                                  strobe;
	logic                                  strbce;
	logic                                  write_b;
	logic [dmb_vme_pkg::NUM_DEVICES-1:0]   device;
	logic [dmb_vme_pkg::CMD_W-1:0]         command;
	logic [dmb_vme_pkg::VME_DATA_W-1:0]    indata;

	// Command decoder side
	modport ctrl (
		output strobe, strbce, write_b, device, command, indata
	);

	// Device side
	modport dev (
		input strobe, strbce, write_b, device, command, indata
	);

endinterface

/* src/vme_timers.sv */
`timescale 1ns/100ps

module vme_timers (
	input  logic fastclk,
	input  logic jtimer_clr,
	input  logic mid_en_i,
	input  logic slow_en_i,
	input  logic tovme_b_i,
	input  logic vmeready_i,
	output logic data_oe_b_o,
	output logic vme_ready_b_o,
	output logic fpga_rst_o
);

	logic [dmb_timing_pkg::DOE_TIMER_W-1:0] doe_q;
	logic [dmb_timing_pkg::VRD_TIMER_W-1:0] vrd_q;
	logic                                   vmeready_s;
	logic                                   vmeready_d;
	logic                                   ready_q;

	// Output enable window, counts slow ticks after the bus turns toward VME
	always_ff @(posedge fastclk or posedge jtimer_clr) begin
		if (jtimer_clr) begin
			doe_q <= '0;
		end else if (tovme_b_i) begin
			doe_q <= '0;
		end else if (slow_en_i && !doe_q[dmb_timing_pkg::DOE_TIMER_W-1]) begin
			doe_q <= doe_q + 1'b1;
		end
	end

	assign data_oe_b_o = doe_q[dmb_timing_pkg::DOE_TIMER_W-1] & ~tovme_b_i;

	// Edge sample of vmeready on the mid enable
	always_ff @(posedge fastclk or posedge jtimer_clr) begin
		if (jtimer_clr) begin
			vmeready_s <= 1'b0;
			vmeready_d <= 1'b0;
			fpga_rst_o <= 1'b0;
		end else begin
			fpga_rst_o <= mid_en_i & vmeready_s & ~vmeready_d;
			if (mid_en_i) begin
				vmeready_s <= vmeready_i;
				vmeready_d <= vmeready_s;
			end
		end
	end

	// Ready delay, sticky once the counter hits full scale
	always_ff @(posedge fastclk or posedge jtimer_clr) begin
		if (jtimer_clr) begin
			vrd_q   <= '0;
			ready_q <= 1'b0;
		end else if (mid_en_i) begin
			if (!vmeready_i) begin
				vrd_q   <= '0;
				ready_q <= 1'b0;
			end else begin
				ready_q <= ready_q | (vrd_q == '1);
				if (vrd_q != '1) begin
					vrd_q <= vrd_q + 1'b1;
				end
			end
		end
	end

	assign vme_ready_b_o = ~ready_q;

	a_fpga_rst_pulse: assert property (
		@(posedge fastclk) disable iff (jtimer_clr)
		fpga_rst_o |=> !fpga_rst_o
	);

endmodule

/* src/vprom_enable.sv */
`timescale 1ns/100ps

module vprom_enable (
	input  logic   fastclk,
	input  logic   jtimer_clr,
	input  logic   sys_rst_i,
	input  logic   slow2_en_i,
	input  logic   jtag_init_i,
	vme_dev_if.dev bus,
	output logic   vprom_en_o
);

	logic                                  dev_sel;
	logic                                  hold_q;
	logic [dmb_timing_pkg::DVC_HOLD_W-1:0] hold_cnt_q;
	logic                                  cnt_top_q;

	assign dev_sel    = bus.device[dmb_vme_pkg::DEV_VPROM];
	assign vprom_en_o = dev_sel | jtag_init_i | hold_q;

	// Keep the PROM chain enabled for a while after the access
	always_ff @(posedge fastclk or posedge jtimer_clr) begin
		if (jtimer_clr) begin
			hold_q <= 1'b0;
		end else if (sys_rst_i || (cnt_top_q && !dev_sel)) begin
			hold_q <= 1'b0;
		end else begin
			hold_q <= hold_q | dev_sel;
		end
	end

	// Hold counter restarts on every access
	always_ff @(posedge fastclk or posedge jtimer_clr) begin
		if (jtimer_clr) begin
			hold_cnt_q <= '0;
			cnt_top_q  <= 1'b0;
		end else if (sys_rst_i || dev_sel) begin
			hold_cnt_q <= '0;
			cnt_top_q  <= 1'b0;
		end else begin
			if (cnt_top_q) begin
				hold_cnt_q <= '0;
			end else if (slow2_en_i && vprom_en_o) begin
				hold_cnt_q <= hold_cnt_q + 1'b1;
			end
			if (slow2_en_i) begin
				cnt_top_q <= hold_cnt_q[dmb_timing_pkg::DVC_HOLD_W-1];
			end
		end
	end

	// Hold flag keeps the enable on until the counter tops out
	a_hold_enables: assert property (
		@(posedge fastclk) disable iff (jtimer_clr)
		hold_q && !cnt_top_q && !sys_rst_i |=> vprom_en_o
	);

endmodule

/* verif/dmb_ctrl_tb.sv */
`timescale 1ns/100ps

module dmb_ctrl_tb;

	logic                                fastclk;
	logic                                jtimer_clr;
	logic                                strobe_i;
	logic                                strbce_i;
	logic                                write_b_i;
	logic [dmb_vme_pkg::NUM_DEVICES-1:0] device_i;
	logic [dmb_vme_pkg::CMD_W-1:0]       command_i;
	logic [dmb_vme_pkg::VME_DATA_W-1:0]  indata_i;
	logic                                softrst_i;
	logic                                donetrg_i;
	logic                                vmeready_i;
	logic                                tovme_b_i;
	logic                                cfeb_tck_i;
	dmb_vme_pkg::cfeb_sel_t              cfeb_tdo_i;
	logic                                dtack_b_o;
	logic [dmb_vme_pkg::VME_DATA_W-1:0]  outdata_o;
	logic                                data_oe_b_o;
	logic                                vme_ready_b_o;
	logic                                jtag_init_o;
	dmb_vme_pkg::cfeb_sel_t              cfeb_tck_o;
	logic                                cfeb_tdo_o;
	logic                                vprom_en_o;

	logic [31:0] rng_state;
	int          cycle_cnt = 0;

	typedef enum {SIG_INIT, SIG_DTACK, SIG_OE, SIG_READY, SIG_VPROM} probe_t;

	dmb_ctrl_top uut (
		.fastclk       (fastclk),
		.jtimer_clr    (jtimer_clr),
		.strobe_i      (strobe_i),
		.strbce_i      (strbce_i),
		.write_b_i     (write_b_i),
		.device_i      (device_i),
		.command_i     (command_i),
		.indata_i      (indata_i),
		.softrst_i     (softrst_i),
		.donetrg_i     (donetrg_i),
		.vmeready_i    (vmeready_i),
		.tovme_b_i     (tovme_b_i),
		.cfeb_tck_i    (cfeb_tck_i),
		.cfeb_tdo_i    (cfeb_tdo_i),
		.dtack_b_o     (dtack_b_o),
		.outdata_o     (outdata_o),
		.data_oe_b_o   (data_oe_b_o),
		.vme_ready_b_o (vme_ready_b_o),
		.jtag_init_o   (jtag_init_o),
		.cfeb_tck_o    (cfeb_tck_o),
		.cfeb_tdo_o    (cfeb_tdo_o),
		.vprom_en_o    (vprom_en_o)
	);

	always #50 fastclk = ~fastclk;

	// Elapsed time in fastclk cycles
	always @(posedge fastclk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int count_ones(input dmb_vme_pkg::cfeb_sel_t v);
		int n;
		int i;
		n = 0;
		for (i = 0; i < dmb_vme_pkg::NUM_CFEB; i++) begin
			if (v[i]) begin
				n++;
			end
		end
		return n;
	endfunction

	function automatic logic read_output(input probe_t sig);
		case (sig)
			SIG_INIT:  return jtag_init_o;
			SIG_DTACK: return dtack_b_o;
			SIG_OE:    return data_oe_b_o;
			SIG_READY: return vme_ready_b_o;
			default:   return vprom_en_o;
		endcase
	endfunction

	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		assert (actual == expected) else begin
			stop_with_error($sformatf("FAIL %s expected %0h actual %0h",
				name, expected, actual));
		end
	endtask

	task automatic check_range(input string name, input int lo, input int hi, input int actual);
		assert (actual >= lo && actual <= hi) else begin
			stop_with_error($sformatf("FAIL %s expected %0d..%0d actual %0d",
				name, lo, hi, actual));
		end
	endtask

	// Steps falling edges until the output reaches the level
	task automatic wait_for(input probe_t sig, input logic level, input int limit,
		input string what);
		int n;
		n = 0;
		do begin
			@(negedge fastclk);
			n++;
		end while (read_output(sig) !== level && n < limit);
		if (read_output(sig) !== level) begin
			stop_with_error({"Timeout waiting for ", what});
		end
	endtask

	// One full init pulse, 16 slow2 periods high
	task automatic check_init_pulse(input string name);
		int t0;
		wait_for(SIG_INIT, 1'b1, 40 * 32, {name, " rise"});
		t0 = cycle_cnt;
		wait_for(SIG_INIT, 1'b0, 20 * 32, {name, " fall"});
		check_range(name, 15 * 32, 17 * 32, cycle_cnt - t0);
	endtask

	task automatic cfeb_access(input logic [dmb_vme_pkg::CMD_W-1:0] cmd, input logic rd,
		input logic [15:0] data, output logic [15:0] rdata);
		device_i = '0;
		device_i[dmb_vme_pkg::DEV_CFEB] = 1'b1;
		command_i = cmd;
		write_b_i = rd;
		indata_i  = data;
		strobe_i  = 1'b1;
		wait_for(SIG_DTACK, 1'b0, 8, "dtack_b_o low");
		strbce_i = 1'b1;
		@(negedge fastclk);
		strbce_i  = 1'b0;
		rdata     = outdata_o;
		strobe_i  = 1'b0;
		device_i  = '0;
		command_i = '0;
		wait_for(SIG_DTACK, 1'b1, 8, "dtack_b_o release");
	endtask

	task automatic check_routing(input dmb_vme_pkg::cfeb_sel_t sel);
		dmb_vme_pkg::cfeb_sel_t tdo;
		dmb_vme_pkg::cfeb_sel_t exp_tck;
		logic                   tck;
		logic                   exp_tdo;
		rng_state  = xorshift32(rng_state);
		tdo        = rng_state[4:0];
		tck        = rng_state[8];
		cfeb_tdo_i = tdo;
		cfeb_tck_i = tck;
		// Selected boards see the clock, the others stay low
		exp_tck    = tck ? sel : '0;
		exp_tdo    = (count_ones(sel) == 1) ? |(tdo & sel) : 1'b0;
		@(negedge fastclk);
		check_value("cfeb_tck", int'(exp_tck), int'(cfeb_tck_o));
		check_value("cfeb_tdo", int'(exp_tdo), int'(cfeb_tdo_o));
	endtask

	//////////////////////////////////////////////////
	// Checks that run all the time
	//////////////////////////////////////////////////
	a_dtack_needs_cfeb: assert property (
		@(posedge fastclk) disable iff (jtimer_clr)
		!dtack_b_o |-> $past(device_i[dmb_vme_pkg::DEV_CFEB] && strobe_i)
	) else stop_with_error("dtack_b_o went low without a device 1 access");

	a_oe_off_toward_dmb: assert property (
		@(posedge fastclk) disable iff (jtimer_clr)
		tovme_b_i |-> !data_oe_b_o
	) else stop_with_error("data_oe_b_o was high while tovme_b_i was high");

	a_vprom_on_access: assert property (
		@(posedge fastclk) disable iff (jtimer_clr)
		device_i[dmb_vme_pkg::DEV_VPROM] |-> vprom_en_o
	) else stop_with_error("vprom_en_o was low during a device 4 access");

	initial begin
		logic [15:0] wdata;
		logic [15:0] rdata;
		int          i;
		int          t0;
		fastclk    = 1'b0;
		jtimer_clr = 1'b1;
		strobe_i   = 1'b0;
		strbce_i   = 1'b0;
		write_b_i  = 1'b1;
		device_i   = '0;
		command_i  = '0;
		indata_i   = '0;
		softrst_i  = 1'b0;
		donetrg_i  = 1'b0;
		vmeready_i = 1'b0;
		tovme_b_i  = 1'b1;
		cfeb_tck_i = 1'b0;
		cfeb_tdo_i = '0;
		rng_state  = 32'd1862;
		repeat (16) @(negedge fastclk);
		jtimer_clr = 1'b0;

		// Init sequence after reset and after a soft reset
		check_init_pulse("reset_init");
		softrst_i = 1'b1;
		donetrg_i = 1'b1;
		@(negedge fastclk);
		softrst_i = 1'b0;
		check_init_pulse("softrst_init");
		donetrg_i = 1'b0;
		softrst_i = 1'b1;
		@(negedge fastclk);
		softrst_i = 1'b0;
		repeat (40 * 32) begin
			@(negedge fastclk);
			check_value("softrst_no_done", 0, int'(jtag_init_o));
		end

		// Select register writes, readback and JTAG routing
		cfeb_access(dmb_vme_pkg::CMD_CFEB_READ, 1'b1, '0, rdata);
		check_value("cfeb_reset_read", int'(5'h1f), int'(rdata));
		for (i = 0; i < 16; i++) begin
			rng_state = xorshift32(rng_state);
			wdata     = rng_state[15:0];
			if (i % 2 == 0) begin
				wdata[4:0] = 5'b00001 << (rng_state[20:16] % 5);
			end
			cfeb_access(dmb_vme_pkg::CMD_CFEB_SEL, 1'b0, wdata, rdata);
			cfeb_access(dmb_vme_pkg::CMD_CFEB_READ, 1'b1, '0, rdata);
			check_value("cfeb_readback", int'(wdata[4:0]), int'(rdata));
			repeat (2) check_routing(wdata[4:0]);
		end

		// Data output enable window
		tovme_b_i = 1'b0;
		t0 = cycle_cnt;
		wait_for(SIG_OE, 1'b1, 140 * 16, "data_oe_b_o high");
		check_range("oe_delay", 127 * 16, 129 * 16, cycle_cnt - t0);
		tovme_b_i = 1'b1;
		@(negedge fastclk);
		check_value("oe_release", 0, int'(data_oe_b_o));

		// VME ready restarts init, then the long ready delay
		vmeready_i = 1'b1;
		t0 = cycle_cnt;
		check_init_pulse("vmeready_init");
		wait_for(SIG_READY, 1'b0, 65540 * 4, "vme_ready_b_o low");
		check_range("ready_delay", 65535 * 4, 65537 * 4, cycle_cnt - t0);
		vmeready_i = 1'b0;
		wait_for(SIG_READY, 1'b1, 8, "vme_ready_b_o release");

		// PROM enable and its hold time
		device_i = '0;
		device_i[dmb_vme_pkg::DEV_VPROM] = 1'b1;
		strobe_i = 1'b1;
		wait_for(SIG_VPROM, 1'b1, 4, "vprom_en_o high");
		device_i = '0;
		strobe_i = 1'b0;
		t0 = cycle_cnt;
		wait_for(SIG_VPROM, 1'b0, 260 * 32, "vprom_en_o release");
		check_range("vprom_hold", 127 * 32, 257 * 32, cycle_cnt - t0);

		$display("No errors");
		$finish;
	end

endmodule
